//--- logic/stbuf_defs.svh
/* Store buffer sizing */

`ifndef STBUF_DEFS_SVH
`define STBUF_DEFS_SVH

// Store buffer
`define STBUF_ENTRIES     4
`define STBUF_LINE_BYTES  8
`define STBUF_ADDR_W      16

// Derived line geometry
`define STBUF_OFFS_W      3
`define STBUF_DATA_W      (`STBUF_LINE_BYTES * 8)
`define STBUF_LINE_W      (`STBUF_ADDR_W - `STBUF_OFFS_W)

// L1D array
`define L1D_SETS          8
`define L1D_IDX_W         3

`endif

//--- logic/stbuf_pkg.sv
/* Store buffer types */

`default_nettype none
`include "stbuf_defs.svh"

package stbuf_pkg;

  // Entry FSM
  typedef enum logic [2:0] {
    IDLE,
    RD_L1D,       // Hit check read
    RESP_L1D,
    WR_L1D,       // Write on hit
    REFILL_REQ,
    WAIT_REFILL,
    MERGE_L1D,    // Write after refill
    WAIT_FINISH
  } stbuf_state_e;

  // Array operation
  typedef enum logic [1:0] {
    READ,
    WRITE,
    REFILL
  } l1d_op_e;

  typedef struct packed {
    logic                          valid;
    logic [`STBUF_LINE_W-1:0]      line;
    logic [`STBUF_DATA_W-1:0]      data;
    logic [`STBUF_LINE_BYTES-1:0]  strb;
  } stbuf_entry_t;

endpackage

`default_nettype wire

//--- logic/l1d_req_if.sv
/* L1D request channel */

`timescale 1ns/1ps
`default_nettype none
`include "stbuf_defs.svh"

interface l1d_req_if
  import stbuf_pkg::*;
();

  // Requester side
  logic                          req;
  l1d_op_e                       op;
  logic [`STBUF_LINE_W-1:0]      line;
  logic [`STBUF_DATA_W-1:0]      wdata;
  logic [`STBUF_LINE_BYTES-1:0]  strb;

  // Array side
  logic                          gnt;    // One cycle
  logic                          hit;    // Valid with done of a read
  logic [`STBUF_DATA_W-1:0]      rdata;
  logic                          done;

  modport requester (output req, op, line, wdata, strb,
                     input  gnt, hit, rdata, done);

  modport arbiter   (input  req, op, line, wdata, strb,
                     output gnt, hit, rdata, done);

endinterface

`default_nettype wire

//--- logic/stbuf_entry.sv
/* Store buffer entry */

`timescale 1ns/1ps
`default_nettype none
`include "stbuf_defs.svh"

module stbuf_entry
  import stbuf_pkg::*;
(
  input  logic                      i_clk,
  input  logic                      i_reset_n,

  input  logic                      i_load,     // Allocate with i_entry
  input  logic                      i_merge,    // Merge i_entry bytes
  input  stbuf_entry_t              i_entry,

  input  logic                      i_ld_valid,
  input  logic [`STBUF_LINE_W-1:0]  i_ld_line,
  output logic                      o_fwd_hit,

  output stbuf_entry_t              o_entry,
  output logic                      o_ready_to_merge,

  l1d_req_if.requester              l1d
);

  stbuf_entry_t r_entry;
  stbuf_entry_t w_entry_next;
  stbuf_state_e r_state;
  stbuf_state_e w_state_next;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state       <= IDLE;
      r_entry.valid <= 1'b0;
    end else begin
      r_state <= w_state_next;
      r_entry <= w_entry_next;
    end
  end

  always_comb begin
    w_entry_next = r_entry;
    w_state_next = r_state;

    // Younger store bytes win
    if (r_entry.valid && i_merge) begin
      for (int b = 0; b < `STBUF_LINE_BYTES; b++) begin
        if (i_entry.strb[b]) begin
          w_entry_next.strb[b]        = 1'b1;
          w_entry_next.data[b*8 +: 8] = i_entry.data[b*8 +: 8];
        end
      end
    end

    case (r_state)
      IDLE: begin
        if (i_load) begin
          w_entry_next = i_entry;
          w_state_next = RD_L1D;
        end
      end
      RD_L1D:      if (l1d.gnt)  w_state_next = RESP_L1D;
      RESP_L1D:    if (l1d.done) w_state_next = l1d.hit ? WR_L1D : REFILL_REQ;
      REFILL_REQ:  if (l1d.gnt)  w_state_next = WAIT_REFILL;
      WAIT_REFILL: if (l1d.done) w_state_next = MERGE_L1D;
      WR_L1D,
      MERGE_L1D:   if (l1d.gnt)  w_state_next = WAIT_FINISH;
      WAIT_FINISH: begin
        // Write-through reached memory
        if (l1d.done) begin
          w_state_next       = IDLE;
          w_entry_next.valid = 1'b0;
        end
      end
      default:     w_state_next = IDLE;
    endcase
  end

  // ------------------------------------------------------------------------
  // Array request
  // ------------------------------------------------------------------------
  assign l1d.req = r_entry.valid &
                   ((r_state == RD_L1D) | (r_state == WR_L1D) |
                    (r_state == REFILL_REQ) | (r_state == MERGE_L1D));

  always_comb begin
    case (r_state)
      RD_L1D:     l1d.op = READ;
      REFILL_REQ: l1d.op = REFILL;
      default:    l1d.op = WRITE;
    endcase
  end

  assign l1d.line  = r_entry.line;
  assign l1d.wdata = r_entry.data;
  assign l1d.strb  = r_entry.strb;

  // Write data is frozen from WR_L1D or MERGE_L1D on
  assign o_ready_to_merge = r_entry.valid &
                            ((r_state == RD_L1D) | (r_state == RESP_L1D) |
                             (r_state == REFILL_REQ) | (r_state == WAIT_REFILL));

  assign o_fwd_hit = r_entry.valid & i_ld_valid & (r_entry.line == i_ld_line);
  assign o_entry   = r_entry;

endmodule

`default_nettype wire

//--- logic/l1d_arbiter.sv
/* L1D round-robin arbiter */

`timescale 1ns/1ps
`default_nettype none
`include "stbuf_defs.svh"

module l1d_arbiter
  import stbuf_pkg::*;
(
  input  logic                      i_clk,
  input  logic                      i_reset_n,

  l1d_req_if.arbiter                ent [`STBUF_ENTRIES],

  input  logic                      i_ld_valid,
  input  logic [`STBUF_LINE_W-1:0]  i_ld_line,
  output logic                      o_ld_done,
  output logic                      o_ld_hit,
  output logic [`STBUF_DATA_W-1:0]  o_ld_data,

  l1d_req_if.requester              arr
);

  localparam int N     = `STBUF_ENTRIES;
  localparam int IDX_W = $clog2(N);

  // Flattened entry requests
  logic [N-1:0]                  w_req;
  l1d_op_e                       w_op    [N];
  logic [`STBUF_LINE_W-1:0]      w_line  [N];
  logic [`STBUF_DATA_W-1:0]      w_wdata [N];
  logic [`STBUF_LINE_BYTES-1:0]  w_strb  [N];

  logic              r_busy;     // Operation in flight
  logic              r_own_ld;   // Load port owns it
  logic [IDX_W-1:0]  r_owner;
  logic [IDX_W-1:0]  r_ptr;      // Round-robin start

  logic              w_pick_ld;
  logic              w_pick_vld;
  logic [IDX_W-1:0]  w_pick;

  for (genvar g = 0; g < N; g++) begin : g_ent
    assign w_req[g]   = ent[g].req;
    assign w_op[g]    = ent[g].op;
    assign w_line[g]  = ent[g].line;
    assign w_wdata[g] = ent[g].wdata;
    assign w_strb[g]  = ent[g].strb;

    assign ent[g].gnt   = arr.gnt & ~w_pick_ld & (w_pick == IDX_W'(g));
    assign ent[g].done  = arr.done & r_busy & ~r_own_ld & (r_owner == IDX_W'(g));
    assign ent[g].hit   = arr.hit;
    assign ent[g].rdata = arr.rdata;
  end

  always_comb begin
    int idx;
    w_pick_ld  = i_ld_valid;   // Load port first
    w_pick_vld = 1'b0;
    w_pick     = r_ptr;
    for (int k = 0; k < N; k++) begin
      idx = (int'(r_ptr) + k) % N;
      if (!w_pick_vld && w_req[idx]) begin
        w_pick_vld = 1'b1;
        w_pick     = IDX_W'(idx);
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_busy   <= 1'b0;
      r_own_ld <= 1'b0;
      r_owner  <= '0;
      r_ptr    <= '0;
    end else if (arr.gnt) begin
      r_busy   <= 1'b1;
      r_own_ld <= w_pick_ld;
      r_owner  <= w_pick;
      if (!w_pick_ld) begin
        r_ptr <= w_pick + 1'b1;
      end
    end else if (arr.done) begin
      r_busy <= 1'b0;
    end
  end

  // Request mux to the array
  assign arr.req   = ~r_busy & (w_pick_ld | w_pick_vld);
  assign arr.op    = w_pick_ld ? READ : w_op[w_pick];
  assign arr.line  = w_pick_ld ? i_ld_line : w_line[w_pick];
  assign arr.wdata = w_wdata[w_pick];
  assign arr.strb  = w_pick_ld ? '0 : w_strb[w_pick];

  assign o_ld_done = arr.done & r_busy & r_own_ld;
  assign o_ld_hit  = arr.hit;
  assign o_ld_data = arr.rdata;

endmodule

`default_nettype wire

//--- logic/l1d_array.sv
/* Direct-mapped L1D with APB master */

`timescale 1ns/1ps
`default_nettype none
`include "stbuf_defs.svh"

module l1d_array
  import stbuf_pkg::*;
(
  input  logic                          i_clk,
  input  logic                          i_reset_n,

  l1d_req_if.arbiter                    req,

  output logic                          o_psel,
  output logic                          o_penable,
  output logic                          o_pwrite,
  output logic [`STBUF_ADDR_W-1:0]      o_paddr,
  output logic [`STBUF_DATA_W-1:0]      o_pwdata,
  output logic [`STBUF_LINE_BYTES-1:0]  o_pstrb,
  input  logic                          i_pready,
  input  logic [`STBUF_DATA_W-1:0]      i_prdata
);

  localparam int SETS  = `L1D_SETS;
  localparam int IDX_W = `L1D_IDX_W;
  localparam int TAG_W = `STBUF_LINE_W - IDX_W;

  typedef enum logic [1:0] {
    ARR_IDLE,
    ARR_RD_RESP,
    ARR_SETUP,    // APB setup phase
    ARR_ACCESS
  } arr_state_e;

  arr_state_e                    r_state;
  l1d_op_e                       r_op;
  logic [`STBUF_LINE_W-1:0]      r_line;
  logic [`STBUF_DATA_W-1:0]      r_wdata;
  logic [`STBUF_LINE_BYTES-1:0]  r_strb;
  logic                          r_hit;
  logic [`STBUF_DATA_W-1:0]      r_rdata;

  logic [SETS-1:0]               r_valid;
  logic [TAG_W-1:0]              r_tag  [SETS];
  logic [`STBUF_DATA_W-1:0]      r_data [SETS];

  logic [IDX_W-1:0]  w_idx;
  logic [TAG_W-1:0]  w_tag;
  logic              w_hit;
  logic              w_wr_hit;
  logic              w_fill;

  assign w_idx    = req.line[IDX_W-1:0];
  assign w_tag    = req.line[`STBUF_LINE_W-1:IDX_W];
  assign w_hit    = r_valid[w_idx] & (r_tag[w_idx] == w_tag);
  assign w_wr_hit = req.gnt & (req.op == WRITE) & w_hit;
  assign w_fill   = (r_state == ARR_ACCESS) & i_pready & (r_op == REFILL);

  assign req.gnt   = req.req & (r_state == ARR_IDLE);
  assign req.done  = (r_state == ARR_RD_RESP) | ((r_state == ARR_ACCESS) & i_pready);
  assign req.hit   = r_hit;
  assign req.rdata = r_rdata;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= ARR_IDLE;
      r_op    <= READ;
      r_valid <= '0;
    end else begin
      case (r_state)
        ARR_IDLE: begin
          if (req.gnt) begin
            r_op    <= req.op;
            r_state <= (req.op == READ) ? ARR_RD_RESP : ARR_SETUP;
          end
        end
        ARR_RD_RESP: r_state <= ARR_IDLE;
        ARR_SETUP:   r_state <= ARR_ACCESS;
        ARR_ACCESS:  if (i_pready) r_state <= ARR_IDLE;   // Wait states
        default:     r_state <= ARR_IDLE;
      endcase
      if (w_fill) begin
        r_valid[r_line[IDX_W-1:0]] <= 1'b1;
      end
    end
  end

  // Request capture and line storage
  always_ff @(posedge i_clk) begin
    if (req.gnt) begin
      r_line  <= req.line;
      r_wdata <= req.wdata;
      r_strb  <= req.strb;
      r_hit   <= (req.op == READ) & w_hit;
      r_rdata <= r_data[w_idx];
    end
    if (w_wr_hit) begin
      for (int b = 0; b < `STBUF_LINE_BYTES; b++) begin
        if (req.strb[b]) begin
          r_data[w_idx][b*8 +: 8] <= req.wdata[b*8 +: 8];
        end
      end
    end
    if (w_fill) begin
      r_data[r_line[IDX_W-1:0]] <= i_prdata;
      r_tag[r_line[IDX_W-1:0]]  <= r_line[`STBUF_LINE_W-1:IDX_W];
    end
  end

  // ------------------------------------------------------------------------
  // APB master
  // ------------------------------------------------------------------------
  assign o_psel    = (r_state == ARR_SETUP) | (r_state == ARR_ACCESS);
  assign o_penable = (r_state == ARR_ACCESS);
  assign o_pwrite  = (r_op == WRITE);
  assign o_paddr   = {r_line, {`STBUF_OFFS_W{1'b0}}};
  assign o_pwdata  = r_wdata;
  assign o_pstrb   = (r_op == WRITE) ? r_strb : '0;   // Reads carry no strobes

endmodule

`default_nettype wire

//--- logic/store_buffer_top.sv
/* Store buffer top level */

`timescale 1ns/1ps
`default_nettype none
`include "stbuf_defs.svh"

module store_buffer_top
  import stbuf_pkg::*;
(
  input  logic                          i_clk,
  input  logic                          i_reset_n,

  // Store push
  input  logic                          i_st_valid,
  input  logic [`STBUF_ADDR_W-1:0]      i_st_addr,
  input  logic [`STBUF_DATA_W-1:0]      i_st_data,
  input  logic [`STBUF_LINE_BYTES-1:0]  i_st_strb,
  output logic                          o_st_ready,

  // Load port
  input  logic                          i_ld_valid,
  input  logic [`STBUF_ADDR_W-1:0]      i_ld_addr,
  output logic                          o_fwd_hit,
  output logic [`STBUF_DATA_W-1:0]      o_fwd_data,
  output logic [`STBUF_LINE_BYTES-1:0]  o_fwd_strb,
  output logic                          o_ld_done,
  output logic                          o_ld_hit,
  output logic [`STBUF_DATA_W-1:0]      o_ld_data,

  // APB master
  output logic                          o_psel,
  output logic                          o_penable,
  output logic                          o_pwrite,
  output logic [`STBUF_ADDR_W-1:0]      o_paddr,
  output logic [`STBUF_DATA_W-1:0]      o_pwdata,
  output logic [`STBUF_LINE_BYTES-1:0]  o_pstrb,
  input  logic                          i_pready,
  input  logic [`STBUF_DATA_W-1:0]      i_prdata
);

  localparam int N     = `STBUF_ENTRIES;
  localparam int IDX_W = $clog2(N);

  logic [`STBUF_LINE_W-1:0]  w_st_line;
  logic [`STBUF_LINE_W-1:0]  w_ld_line;
  stbuf_entry_t              w_push_entry;
  stbuf_entry_t              w_entry [N];

  logic [N-1:0]      w_ready_to_merge;
  logic [N-1:0]      w_same_line;
  logic [N-1:0]      w_merge_hit;
  logic [N-1:0]      w_free;
  logic [N-1:0]      w_load;
  logic [N-1:0]      w_merge;
  logic [N-1:0]      w_fwd_hit;
  logic              w_line_locked;
  logic              w_push;
  logic [IDX_W-1:0]  w_free_idx;

  assign w_st_line = i_st_addr[`STBUF_ADDR_W-1:`STBUF_OFFS_W];
  assign w_ld_line = i_ld_addr[`STBUF_ADDR_W-1:`STBUF_OFFS_W];

  assign w_push_entry = '{valid: 1'b1, line: w_st_line, data: i_st_data, strb: i_st_strb};

  // ------------------------------------------------------------------------
  // Allocation
  // ------------------------------------------------------------------------
  // Same line past its merge window blocks a second entry for it
  assign w_line_locked = |(w_same_line & ~w_ready_to_merge);
  assign o_st_ready    = (|w_merge_hit) | ((|w_free) & ~w_line_locked);
  assign w_push        = i_st_valid & o_st_ready;

  always_comb begin
    w_free_idx = '0;
    for (int i = N - 1; i >= 0; i--) begin
      if (w_free[i]) begin
        w_free_idx = IDX_W'(i);   // Lowest free wins
      end
    end
  end

  l1d_req_if ent_if [N] ();
  l1d_req_if arr_if ();

  for (genvar g = 0; g < N; g++) begin : g_entry
    assign w_same_line[g] = w_entry[g].valid & (w_entry[g].line == w_st_line);
    assign w_merge_hit[g] = w_same_line[g] & w_ready_to_merge[g];
    assign w_free[g]      = ~w_entry[g].valid;
    assign w_merge[g]     = w_push & w_merge_hit[g];
    assign w_load[g]      = w_push & ~(|w_merge_hit) & (w_free_idx == IDX_W'(g));

    stbuf_entry u_entry (
      .i_clk            (i_clk),
      .i_reset_n        (i_reset_n),
      .i_load           (w_load[g]),
      .i_merge          (w_merge[g]),
      .i_entry          (w_push_entry),
      .i_ld_valid       (i_ld_valid),
      .i_ld_line        (w_ld_line),
      .o_fwd_hit        (w_fwd_hit[g]),
      .o_entry          (w_entry[g]),
      .o_ready_to_merge (w_ready_to_merge[g]),
      .l1d              (ent_if[g])
    );
  end

  // Forward bytes of the one entry holding the load line
  assign o_fwd_hit = |w_fwd_hit;

  always_comb begin
    o_fwd_data = '0;
    o_fwd_strb = '0;
    for (int i = 0; i < N; i++) begin
      if (w_fwd_hit[i]) begin
        o_fwd_data = o_fwd_data | w_entry[i].data;
        o_fwd_strb = o_fwd_strb | w_entry[i].strb;
      end
    end
  end

  l1d_arbiter u_arbiter (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .ent        (ent_if),
    .i_ld_valid (i_ld_valid),
    .i_ld_line  (w_ld_line),
    .o_ld_done  (o_ld_done),
    .o_ld_hit   (o_ld_hit),
    .o_ld_data  (o_ld_data),
    .arr        (arr_if)
  );

  l1d_array u_array (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .req       (arr_if),
    .o_psel    (o_psel),
    .o_penable (o_penable),
    .o_pwrite  (o_pwrite),
    .o_paddr   (o_paddr),
    .o_pwdata  (o_pwdata),
    .o_pstrb   (o_pstrb),
    .i_pready  (i_pready),
    .i_prdata  (i_prdata)
  );

endmodule

`default_nettype wire

//--- verification/store_buffer_checker.sv
/* Store buffer protocol checks */

`timescale 1ns/1ps
`default_nettype none
`include "stbuf_defs.svh"

module store_buffer_checker
  import stbuf_pkg::*;
(
  input  logic                          i_clk,
  input  logic                          i_reset_n,
  input  logic                          i_psel,
  input  logic                          i_penable,
  input  logic                          i_pwrite,
  input  logic [`STBUF_ADDR_W-1:0]      i_paddr,
  input  logic [`STBUF_DATA_W-1:0]      i_pwdata,
  input  logic [`STBUF_LINE_BYTES-1:0]  i_pstrb,
  input  logic                          i_pready,
  input  logic                          i_st_valid,
  input  logic                          i_st_ready,
  input  stbuf_entry_t                  i_entry [`STBUF_ENTRIES]   // Entry registers
);

  // Setup phase is always followed by access
  a_access_follows_setup: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_psel && !i_penable) |=> (i_psel && i_penable))
    else $error("APB setup phase not followed by access phase");

  // Wait states hold the transfer
  a_stable_in_wait: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_psel && i_penable && !i_pready) |=>
      ($stable(i_paddr) && $stable(i_pwdata) && $stable(i_pwrite) && $stable(i_pstrb)))
    else $error("APB transfer changed during a wait state");

  for (genvar g = 0; g < `STBUF_ENTRIES; g++) begin : g_push
    // A held-off store leaves a free entry free
    a_no_alloc_when_blocked: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      (i_st_valid && !i_st_ready && !i_entry[g].valid) |=> !i_entry[g].valid)
      else $error("Store allocated an entry while ready was low");

    a_no_merge_when_blocked: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      (i_st_valid && !i_st_ready && i_entry[g].valid) |=>
        ($stable(i_entry[g].data) && $stable(i_entry[g].strb)))
      else $error("Store merged into an entry while ready was low");
  end

endmodule

`default_nettype wire

//--- verification/store_buffer_tb.sv
/* Store buffer directed testbench */

`timescale 1ns/1ps
`default_nettype none
`include "stbuf_defs.svh"

module store_buffer_tb;

  localparam int AW          = `STBUF_ADDR_W;
  localparam int DW          = `STBUF_DATA_W;
  localparam int BYTES       = `STBUF_LINE_BYTES;
  localparam int MEM_BYTES   = 2 ** AW;
  localparam int CLK_NS      = 8;
  localparam int N_TESTS     = 5;
  localparam int TEST_CYCLES = 400;    // Upper bound per test
  localparam int WAIT_MAX    = 200;    // Upper bound per wait
  localparam int WATCHDOG_NS = (N_TESTS * TEST_CYCLES + 16) * CLK_NS;

  localparam logic [AW-1:0] LINE_A = 16'h0100;
  localparam logic [AW-1:0] LINE_B = 16'h0550;
  localparam logic [AW-1:0] LINE_C = 16'h0770;
  localparam logic [AW-1:0] LINE_D = 16'h0348;

  logic              i_clk;
  logic              i_reset_n;
  logic              i_st_valid;
  logic [AW-1:0]     i_st_addr;
  logic [DW-1:0]     i_st_data;
  logic [BYTES-1:0]  i_st_strb;
  logic              o_st_ready;
  logic              i_ld_valid;
  logic [AW-1:0]     i_ld_addr;
  logic              o_fwd_hit;
  logic [DW-1:0]     o_fwd_data;
  logic [BYTES-1:0]  o_fwd_strb;
  logic              o_ld_done;
  logic              o_ld_hit;
  logic [DW-1:0]     o_ld_data;
  logic              o_psel;
  logic              o_penable;
  logic              o_pwrite;
  logic [AW-1:0]     o_paddr;
  logic [DW-1:0]     o_pwdata;
  logic [BYTES-1:0]  o_pstrb;
  logic              i_pready;
  logic [DW-1:0]     i_prdata;

  int                seed = 25;
  int                errors;
  int                checks;
  logic              stall;          // Holds pready low
  logic [7:0]        mem     [MEM_BYTES];
  logic [7:0]        ref_mem [MEM_BYTES];
  logic [AW-1:0]     rd_q      [$];  // APB read log
  logic [AW-1:0]     wr_addr_q [$];  // APB write log
  logic [DW-1:0]     wr_data_q [$];
  logic [BYTES-1:0]  wr_strb_q [$];

  store_buffer_top UUT (.*);

  bind store_buffer_top store_buffer_checker u_checker (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_psel     (o_psel),
    .i_penable  (o_penable),
    .i_pwrite   (o_pwrite),
    .i_paddr    (o_paddr),
    .i_pwdata   (o_pwdata),
    .i_pstrb    (o_pstrb),
    .i_pready   (i_pready),
    .i_st_valid (i_st_valid),
    .i_st_ready (o_st_ready),
    .i_entry    (w_entry)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_NS / 2) i_clk = ~i_clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the tests finished");
    $display("Checks failed");
    $finish;
  end

  // --------------------------------------------------------------------------
  // APB memory model
  // --------------------------------------------------------------------------
  task automatic serve_apb();
    int a;
    a = int'(o_paddr);
    if (o_pwrite) begin
      for (int b = 0; b < BYTES; b++) begin
        if (o_pstrb[b]) begin
          mem[a + b] = o_pwdata[b*8 +: 8];
        end
      end
      wr_addr_q.push_back(o_paddr);
      wr_data_q.push_back(o_pwdata);
      wr_strb_q.push_back(o_pstrb);
    end else begin
      for (int b = 0; b < BYTES; b++) begin
        i_prdata[b*8 +: 8] = mem[a + b];
      end
      rd_q.push_back(o_paddr);
    end
  endtask

  initial begin
    int wait_cnt;
    wait_cnt = 0;
    i_pready = 1'b0;
    i_prdata = '0;
    for (int i = 0; i < MEM_BYTES; i++) begin
      mem[i] = 8'($random(seed));
    end
    forever begin
      @(posedge i_clk);
      #1;
      if (i_pready) begin
        i_pready = 1'b0;                       // Transfer ended on this edge
      end else if (o_psel && !o_penable) begin
        wait_cnt = {$random(seed)} % 3;        // 0 to 2 wait states
      end else if (o_psel && o_penable && !stall) begin
        if (wait_cnt > 0) begin
          wait_cnt--;
        end else begin
          serve_apb();
          i_pready = 1'b1;
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  task automatic next_cycle();
    @(posedge i_clk);
    #1;
  endtask

  task automatic note_failure(input string what);
    errors++;
    $display("%s", what);
  endtask

  task automatic expect_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    assert (exp === act) else begin
      errors++;
      $display("ERR %s: expected %h actual %h", name, exp, act);
    end
  endtask

  function automatic logic [DW-1:0] byte_mask(input logic [BYTES-1:0] strb);
    logic [DW-1:0] m;
    for (int b = 0; b < BYTES; b++) begin
      m[b*8 +: 8] = {8{strb[b]}};
    end
    return m;
  endfunction

  function automatic logic [DW-1:0] ref_line(input logic [AW-1:0] addr);
    logic [DW-1:0] v;
    for (int b = 0; b < BYTES; b++) begin
      v[b*8 +: 8] = ref_mem[(int'(addr) & ~(BYTES - 1)) + b];
    end
    return v;
  endfunction

  // Expected memory after a store
  task automatic apply_store(input logic [AW-1:0] addr, input logic [DW-1:0] data,
                             input logic [BYTES-1:0] strb);
    for (int b = 0; b < BYTES; b++) begin
      if (strb[b]) begin
        ref_mem[(int'(addr) & ~(BYTES - 1)) + b] = data[b*8 +: 8];
      end
    end
  endtask

  task automatic clear_logs();
    rd_q.delete();
    wr_addr_q.delete();
    wr_data_q.delete();
    wr_strb_q.delete();
  endtask

  task automatic set_stall(input logic value);
    @(negedge i_clk);
    stall = value;
    next_cycle();
  endtask

  task automatic push_store(input logic [AW-1:0] addr, input logic [DW-1:0] data,
                            input logic [BYTES-1:0] strb);
    int n;
    n = 0;
    i_st_valid = 1'b1;
    i_st_addr  = addr;
    i_st_data  = data;
    i_st_strb  = strb;
    @(negedge i_clk);
    while (!o_st_ready && n < WAIT_MAX) begin
      @(negedge i_clk);
      n++;
    end
    if (!o_st_ready) begin
      note_failure($sformatf("Store to %h was never accepted", addr));
    end
    next_cycle();
    i_st_valid = 1'b0;
  endtask

  task automatic wait_writes(input string name, input int count);
    int n;
    n = 0;
    @(negedge i_clk);
    while (wr_addr_q.size() < count && n < WAIT_MAX) begin
      @(negedge i_clk);
      n++;
    end
    if (wr_addr_q.size() < count) begin
      note_failure($sformatf("%s: expected APB writes did not arrive", name));
    end
    next_cycle();
  endtask

  task automatic wait_psel(input string name);
    int n;
    n = 0;
    @(negedge i_clk);
    while (!o_psel && n < WAIT_MAX) begin
      @(negedge i_clk);
      n++;
    end
    if (!o_psel) begin
      note_failure($sformatf("%s: no APB transfer started", name));
    end
    next_cycle();
  endtask

  task automatic load_line(input logic [AW-1:0] addr, output logic hit,
                           output logic [DW-1:0] data);
    int n;
    n = 0;
    i_ld_valid = 1'b1;
    i_ld_addr  = addr;
    @(negedge i_clk);
    while (!o_ld_done && n < WAIT_MAX) begin
      @(negedge i_clk);
      n++;
    end
    if (!o_ld_done) begin
      note_failure($sformatf("Load of %h never completed", addr));
    end
    hit  = o_ld_hit;
    data = o_ld_data;
    next_cycle();
    i_ld_valid = 1'b0;
  endtask

  // Oldest logged write against the expected memory
  task automatic check_write(input string name, input logic [AW-1:0] addr,
                             input logic [BYTES-1:0] strb);
    logic [DW-1:0] mask;
    mask = byte_mask(strb);
    if (wr_addr_q.size() == 0) begin
      note_failure($sformatf("%s: no APB write to check", name));
    end else begin
      expect_eq({name, " paddr"}, addr, wr_addr_q[0]);
      expect_eq({name, " pstrb"}, strb, wr_strb_q[0]);
      expect_eq({name, " pwdata"}, ref_line(addr) & mask, wr_data_q[0] & mask);
      void'(wr_addr_q.pop_front());
      void'(wr_data_q.pop_front());
      void'(wr_strb_q.pop_front());
    end
  endtask

  // --------------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------------
  task automatic test_miss();
    clear_logs();
    push_store(LINE_A, 64'h1122_3344_5566_7788, 8'h0F);
    apply_store(LINE_A, 64'h1122_3344_5566_7788, 8'h0F);
    wait_writes("miss", 1);
    expect_eq("miss reads", 1, rd_q.size());
    if (rd_q.size() > 0) begin
      expect_eq("miss read paddr", LINE_A, rd_q[0]);
    end
    check_write("miss", LINE_A, 8'h0F);
  endtask

  task automatic test_hit();
    logic          hit;
    logic [DW-1:0] data;
    clear_logs();
    push_store(LINE_A, 64'hA1B2_0000_0000_0000, 8'hC0);
    apply_store(LINE_A, 64'hA1B2_0000_0000_0000, 8'hC0);
    wait_writes("hit", 1);
    expect_eq("hit reads", 0, rd_q.size());   // Line already cached
    check_write("hit", LINE_A, 8'hC0);
    load_line(LINE_A, hit, data);
    expect_eq("hit ld_hit", 1, hit);
    expect_eq("hit ld_data", ref_line(LINE_A), data);
  endtask

  task automatic test_merge();
    clear_logs();
    push_store(LINE_D, 64'h0000_3344_0000_5566, 8'h33);
    push_store(LINE_D, 64'h0000_0000_99AA_BBCC, 8'h0F);
    apply_store(LINE_D, 64'h0000_3344_0000_5566, 8'h33);
    apply_store(LINE_D, 64'h0000_0000_99AA_BBCC, 8'h0F);
    wait_writes("merge", 1);
    check_write("merge", LINE_D, 8'h3F);
  endtask

  task automatic test_forward();
    logic [DW-1:0] data;
    data = 64'hFEED_0000_C0DE_0000;
    clear_logs();
    set_stall(1'b1);
    push_store(LINE_B, data, 8'hCC);
    apply_store(LINE_B, data, 8'hCC);
    wait_psel("forward");                     // Refill now stalled
    i_ld_valid = 1'b1;
    i_ld_addr  = LINE_B;
    @(negedge i_clk);
    expect_eq("forward fwd_hit", 1, o_fwd_hit);
    expect_eq("forward fwd_strb", 8'hCC, o_fwd_strb);
    expect_eq("forward fwd_data", data & byte_mask(8'hCC), o_fwd_data & byte_mask(8'hCC));
    next_cycle();
    i_ld_addr = LINE_C;
    @(negedge i_clk);
    expect_eq("forward other line", 0, o_fwd_hit);
    next_cycle();
    i_ld_valid = 1'b0;
    set_stall(1'b0);
    wait_writes("forward", 1);
    check_write("forward", LINE_B, 8'hCC);
  endtask

  task automatic test_full();
    logic [AW-1:0]    lines [5];
    logic [DW-1:0]    datas [5];
    logic [BYTES-1:0] strbs [5];
    logic [4:0]       seen;
    int               k;
    seen = '0;
    clear_logs();
    for (int i = 0; i < 5; i++) begin
      lines[i] = 16'h2000 + 16'(i * 16'h0108);   // Five distinct lines
      datas[i] = {$random(seed), $random(seed)};
      strbs[i] = 8'($random(seed)) | 8'h01;
    end
    set_stall(1'b1);
    for (int i = 0; i < 4; i++) begin
      push_store(lines[i], datas[i], strbs[i]);
      apply_store(lines[i], datas[i], strbs[i]);
    end
    i_st_valid = 1'b1;
    i_st_addr  = lines[4];
    i_st_data  = datas[4];
    i_st_strb  = strbs[4];
    @(negedge i_clk);
    expect_eq("full st_ready", 0, o_st_ready);
    next_cycle();
    i_st_valid = 1'b0;
    set_stall(1'b0);
    push_store(lines[4], datas[4], strbs[4]);
    apply_store(lines[4], datas[4], strbs[4]);
    wait_writes("full", 5);
    while (wr_addr_q.size() > 0) begin
      k = -1;
      for (int i = 0; i < 5; i++) begin
        if (lines[i] == wr_addr_q[0]) begin
          k = i;
        end
      end
      if (k < 0) begin
        note_failure($sformatf("full: APB write to unexpected address %h", wr_addr_q[0]));
        void'(wr_addr_q.pop_front());
        void'(wr_data_q.pop_front());
        void'(wr_strb_q.pop_front());
      end else begin
        seen[k] = 1'b1;
        check_write("full", lines[k], strbs[k]);
      end
    end
    expect_eq("full lines written", 5'h1F, seen);
  endtask

  initial begin
    errors     = 0;
    checks     = 0;
    stall      = 1'b0;
    i_reset_n  = 1'b0;
    i_st_valid = 1'b0;
    i_st_addr  = '0;
    i_st_data  = '0;
    i_st_strb  = '0;
    i_ld_valid = 1'b0;
    i_ld_addr  = '0;
    repeat (4) @(posedge i_clk);
    #1;
    i_reset_n = 1'b1;
    for (int i = 0; i < MEM_BYTES; i++) begin
      ref_mem[i] = mem[i];                    // Model filled at time zero
    end

    @(negedge i_clk);
    expect_eq("reset psel", 0, o_psel);
    expect_eq("reset penable", 0, o_penable);
    expect_eq("reset ld_done", 0, o_ld_done);
    expect_eq("reset fwd_hit", 0, o_fwd_hit);
    expect_eq("reset st_ready", 1, o_st_ready);
    next_cycle();

    test_miss();
    test_hit();
    test_merge();
    test_forward();
    test_full();

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+logic
logic/stbuf_pkg.sv
logic/l1d_req_if.sv
logic/stbuf_entry.sv
logic/l1d_arbiter.sv
logic/l1d_array.sv
logic/store_buffer_top.sv
verification/store_buffer_checker.sv
verification/store_buffer_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= store_buffer_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Checks failed
PASS_MSG  := All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
